// ==== opl_defines.svh ====
// Output port lookup shared constants
// Stream widths, header field positions, protocol codes, port masks and
// register offsets used by the router lookup stage
`ifndef OPL_DEFINES_SVH
`define OPL_DEFINES_SVH

`define OPL_DATA_W        256
`define OPL_STRB_W        32
`define OPL_USER_W        128

`define OPL_SRC_PORT_POS  16      // Low bit of 8-bit source port field
`define OPL_DST_PORT_POS  24      // Low bit of 8-bit destination port field

`define OPL_ETHTYPE_HI    159
`define OPL_ETHTYPE_LO    144
`define OPL_IPVER_HI      143
`define OPL_IPVER_LO      140
`define OPL_PROTO_HI      71
`define OPL_PROTO_LO      64

`define OPL_ETHTYPE_ARP   16'h0806
`define OPL_ETHTYPE_IPV4  16'h0800
`define OPL_IPVER_4       4'd4
`define OPL_PROTO_OSPF    8'd89

// One-hot destination masks
`define OPL_PORT_NF0      8'h01
`define OPL_PORT_NF1      8'h04
`define OPL_PORT_NF2      8'h10
`define OPL_PORT_NF3      8'h40

`define OPL_REG_IPV4      4'h0
`define OPL_REG_ARP       4'h4
`define OPL_REG_OSPF      4'h8
`define OPL_REG_SPARE     4'hC

`define OPL_AXIL_ADDR_W   32
`define OPL_AXIL_DATA_W   32

`endif

// ==== opl_pkg.sv ====
// Output port lookup types
// Stream payload, packed beat, port mask and counter types

`include "opl_defines.svh"

package opl_pkg;

  // 8 words of 32 bits
  typedef logic [`OPL_DATA_W-1:0] tdata_t;

  typedef logic [`OPL_STRB_W-1:0] tstrb_t;

  // 4 words of 32 bits
  typedef logic [`OPL_USER_W-1:0] tuser_t;

  // One stream beat as stored in the FIFO
  typedef struct packed {
    logic   last;
    tuser_t user;
    tstrb_t strb;
    tdata_t data;
  } beat_t;

  typedef logic [7:0] port_mask_t;       // One-hot port vector

  typedef logic [`OPL_AXIL_DATA_W-1:0] counter_t;

endpackage

// ==== opl_beat_fifo.sv ====
// Input beat FIFO
// Small fall-through buffer for stream beats, tready drops when nearly full

`timescale 1ns/1ps
`include "opl_defines.svh"

module opl_beat_fifo #(
  parameter int DEPTH_BITS = 2
) (
  input  logic            AXI_ACLK,
  input  logic            AXI_RESETN,
  input  opl_pkg::tdata_t s_axis_tdata,
  input  opl_pkg::tstrb_t s_axis_tstrb,
  input  opl_pkg::tuser_t s_axis_tuser,
  input  logic            s_axis_tlast,
  input  logic            s_axis_tvalid,
  output logic            s_axis_tready,
  output opl_pkg::beat_t  out_beat,
  output logic            out_valid,
  input  logic            out_ready
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  opl_pkg::beat_t        mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count;
  logic                  wr_en;
  logic                  rd_en;

  assign wr_en = s_axis_tvalid && s_axis_tready;
  assign rd_en = out_valid && out_ready;

  assign s_axis_tready = (count < (DEPTH_BITS+1)'(DEPTH - 1));  // Not nearly full
  assign out_valid     = (count != '0);
  assign out_beat      = mem[rd_ptr];       // Oldest entry, no read latency

  always_ff @(posedge AXI_ACLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= '{last: s_axis_tlast, user: s_axis_tuser,
                       strb: s_axis_tstrb, data: s_axis_tdata};
    end
  end

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // Idle or simultaneous push and pop
      endcase
    end
  end

endmodule

// ==== opl_pkt_classifier.sv ====
// Packet classifier stage
// Registers each beat into a holding stage and flags ARP, IPv4 and OSPF
// from the first beat of every packet

`timescale 1ns/1ps
`include "opl_defines.svh"

module opl_pkt_classifier (
  input  logic            AXI_ACLK,
  input  logic            AXI_RESETN,
  input  opl_pkg::beat_t  in_beat,
  input  logic            in_valid,
  output logic            in_ready,
  output opl_pkg::tdata_t cls_tdata,
  output opl_pkg::tstrb_t cls_tstrb,
  output opl_pkg::tuser_t cls_tuser,
  output logic            cls_tlast,
  output logic            cls_tvalid,
  input  logic            cls_tready,
  output logic            hit_ipv4,
  output logic            hit_arp,
  output logic            hit_ospf
);

  opl_pkg::beat_t hold_q;
  logic           hold_valid;
  logic           first_beat;        // Next accepted beat starts a packet
  logic           accept;
  logic           is_arp;
  logic           is_ipv4_type;
  logic           is_ver4;
  logic           is_ospf_proto;

  // Empty stage, or the held beat leaves this cycle
  assign in_ready = !hold_valid || cls_tready;
  assign accept   = in_valid && in_ready;

  assign is_arp        = (in_beat.data[`OPL_ETHTYPE_HI:`OPL_ETHTYPE_LO] == `OPL_ETHTYPE_ARP);
  assign is_ipv4_type  = (in_beat.data[`OPL_ETHTYPE_HI:`OPL_ETHTYPE_LO] == `OPL_ETHTYPE_IPV4);
  assign is_ver4       = (in_beat.data[`OPL_IPVER_HI:`OPL_IPVER_LO] == `OPL_IPVER_4);
  assign is_ospf_proto = (in_beat.data[`OPL_PROTO_HI:`OPL_PROTO_LO] == `OPL_PROTO_OSPF);

  // Payload holding register
  always_ff @(posedge AXI_ACLK) begin
    if (accept) begin
      hold_q <= in_beat;
    end
  end

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      hold_valid <= 1'b0;
      first_beat <= 1'b1;
      hit_ipv4   <= 1'b0;
      hit_arp    <= 1'b0;
      hit_ospf   <= 1'b0;
    end else begin
      if (accept) begin
        hold_valid <= 1'b1;
        first_beat <= in_beat.last;    // tlast closes the packet
      end else if (cls_tready) begin
        hold_valid <= 1'b0;
      end

      // One-cycle pulses, OSPF check is independent of the version nibble
      hit_arp  <= accept && first_beat && is_arp;
      hit_ipv4 <= accept && first_beat && is_ipv4_type && is_ver4;
      hit_ospf <= accept && first_beat && is_ipv4_type && is_ospf_proto;
    end
  end

  assign cls_tdata  = hold_q.data;
  assign cls_tstrb  = hold_q.strb;
  assign cls_tuser  = hold_q.user;
  assign cls_tlast  = hold_q.last;
  assign cls_tvalid = hold_valid;

endmodule

// ==== opl_port_lookup.sv ====
// Destination port lookup
// Rewrites the destination port field of each packet's first beat from
// its source port, CPU traffic always goes out on nf1

`timescale 1ns/1ps
`include "opl_defines.svh"

module opl_port_lookup (
  input  logic            AXI_ACLK,
  input  logic            AXI_RESETN,
  input  opl_pkg::tdata_t cls_tdata,
  input  opl_pkg::tstrb_t cls_tstrb,
  input  opl_pkg::tuser_t cls_tuser,
  input  logic            cls_tlast,
  input  logic            cls_tvalid,
  output logic            cls_tready,
  output opl_pkg::tdata_t m_axis_tdata,
  output opl_pkg::tstrb_t m_axis_tstrb,
  output opl_pkg::tuser_t m_axis_tuser,
  output logic            m_axis_tlast,
  output logic            m_axis_tvalid,
  input  logic            m_axis_tready
);

  typedef enum logic {ST_HEADER, ST_IN_PKT} state_t;

  state_t              state;
  opl_pkg::port_mask_t src_port;
  logic                from_cpu;
  logic                xfer;

  assign src_port = cls_tuser[`OPL_SRC_PORT_POS +: 8];
  assign from_cpu = src_port[1] || src_port[3] || src_port[5] || src_port[7];
  assign xfer     = cls_tvalid && m_axis_tready;

  // Pure pass-through handshake
  assign m_axis_tvalid = cls_tvalid;
  assign cls_tready    = m_axis_tready;
  assign m_axis_tdata  = cls_tdata;
  assign m_axis_tstrb  = cls_tstrb;
  assign m_axis_tlast  = cls_tlast;

  always_comb begin
    m_axis_tuser = cls_tuser;
    if (state == ST_HEADER) begin
      if (from_cpu) begin
        m_axis_tuser[`OPL_DST_PORT_POS +: 8] = `OPL_PORT_NF1;
      end else if (src_port[6]) begin      // Highest source bit wins
        m_axis_tuser[`OPL_DST_PORT_POS +: 8] = `OPL_PORT_NF2;
      end else if (src_port[4]) begin
        m_axis_tuser[`OPL_DST_PORT_POS +: 8] = `OPL_PORT_NF3;
      end else if (src_port[2]) begin
        m_axis_tuser[`OPL_DST_PORT_POS +: 8] = `OPL_PORT_NF0;
      end else if (src_port[0]) begin
        m_axis_tuser[`OPL_DST_PORT_POS +: 8] = `OPL_PORT_NF1;
      end
    end
  end

  // Single-beat packets stay in ST_HEADER
  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      state <= ST_HEADER;
    end else if (xfer) begin
      state <= cls_tlast ? ST_HEADER : ST_IN_PKT;
    end
  end

endmodule

// ==== opl_stats_regs.sv ====
// Protocol statistics registers
// IPv4, ARP and OSPF packet counters behind a read-only AXI4-Lite port

`timescale 1ns/1ps
`include "opl_defines.svh"

module opl_stats_regs (
  input  logic                        AXI_ACLK,
  input  logic                        AXI_RESETN,
  input  logic                        hit_ipv4,
  input  logic                        hit_arp,
  input  logic                        hit_ospf,
  input  logic [`OPL_AXIL_ADDR_W-1:0] s_axi_araddr,
  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  output logic [`OPL_AXIL_DATA_W-1:0] s_axi_rdata,
  output logic [1:0]                  s_axi_rresp,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready
);

  opl_pkg::counter_t ipv4_cnt;
  opl_pkg::counter_t arp_cnt;
  opl_pkg::counter_t ospf_cnt;
  logic              ar_hs;

  assign s_axi_arready = !s_axi_rvalid;      // One read in flight at most
  assign ar_hs         = s_axi_arvalid && s_axi_arready;
  assign s_axi_rresp   = 2'b00;              // OKAY

  // Counters wrap on overflow
  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      ipv4_cnt <= '0;
      arp_cnt  <= '0;
      ospf_cnt <= '0;
    end else begin
      if (hit_ipv4) ipv4_cnt <= ipv4_cnt + 1'b1;
      if (hit_arp)  arp_cnt  <= arp_cnt + 1'b1;
      if (hit_ospf) ospf_cnt <= ospf_cnt + 1'b1;
    end
  end

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      s_axi_rvalid <= 1'b0;
    end else if (ar_hs) begin
      s_axi_rvalid <= 1'b1;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  // Read data captured at the address handshake
  always_ff @(posedge AXI_ACLK) begin
    if (ar_hs) begin
      case (s_axi_araddr[3:0])
        `OPL_REG_IPV4:  s_axi_rdata <= ipv4_cnt;
        `OPL_REG_ARP:   s_axi_rdata <= arp_cnt;
        `OPL_REG_OSPF:  s_axi_rdata <= ospf_cnt;
        default:        s_axi_rdata <= '0;
      endcase
    end
  end

endmodule

// ==== opl_top.sv ====
// Output port lookup top level
// Input FIFO, classifier and port lookup in a stream pipeline, with the
// protocol counters readable over AXI4-Lite

`timescale 1ns/1ps
`include "opl_defines.svh"

module opl_top (
  input  logic                        AXI_ACLK,
  input  logic                        AXI_RESETN,
  input  opl_pkg::tdata_t             s_axis_tdata,
  input  opl_pkg::tstrb_t             s_axis_tstrb,
  input  opl_pkg::tuser_t             s_axis_tuser,
  input  logic                        s_axis_tvalid,
  output logic                        s_axis_tready,
  input  logic                        s_axis_tlast,
  output opl_pkg::tdata_t             m_axis_tdata,
  output opl_pkg::tstrb_t             m_axis_tstrb,
  output opl_pkg::tuser_t             m_axis_tuser,
  output logic                        m_axis_tvalid,
  input  logic                        m_axis_tready,
  output logic                        m_axis_tlast,
  input  logic [`OPL_AXIL_ADDR_W-1:0] s_axi_araddr,
  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  output logic [`OPL_AXIL_DATA_W-1:0] s_axi_rdata,
  output logic [1:0]                  s_axi_rresp,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready
);

  opl_pkg::beat_t  fifo_beat;
  logic            fifo_valid;
  logic            fifo_ready;
  opl_pkg::tdata_t cls_tdata;
  opl_pkg::tstrb_t cls_tstrb;
  opl_pkg::tuser_t cls_tuser;
  logic            cls_tlast;
  logic            cls_tvalid;
  logic            cls_tready;
  logic            hit_ipv4;
  logic            hit_arp;
  logic            hit_ospf;

  opl_beat_fifo #(
    .DEPTH_BITS (2)
  ) input_fifo (
    .AXI_ACLK      (AXI_ACLK),
    .AXI_RESETN    (AXI_RESETN),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tstrb  (s_axis_tstrb),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .out_beat      (fifo_beat),
    .out_valid     (fifo_valid),
    .out_ready     (fifo_ready)
  );

  opl_pkt_classifier classifier (
    .AXI_ACLK   (AXI_ACLK),
    .AXI_RESETN (AXI_RESETN),
    .in_beat    (fifo_beat),
    .in_valid   (fifo_valid),
    .in_ready   (fifo_ready),
    .cls_tdata  (cls_tdata),
    .cls_tstrb  (cls_tstrb),
    .cls_tuser  (cls_tuser),
    .cls_tlast  (cls_tlast),
    .cls_tvalid (cls_tvalid),
    .cls_tready (cls_tready),
    .hit_ipv4   (hit_ipv4),
    .hit_arp    (hit_arp),
    .hit_ospf   (hit_ospf)
  );

  opl_port_lookup port_lookup (
    .AXI_ACLK      (AXI_ACLK),
    .AXI_RESETN    (AXI_RESETN),
    .cls_tdata     (cls_tdata),
    .cls_tstrb     (cls_tstrb),
    .cls_tuser     (cls_tuser),
    .cls_tlast     (cls_tlast),
    .cls_tvalid    (cls_tvalid),
    .cls_tready    (cls_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tstrb  (m_axis_tstrb),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

  // Counters sit beside the stream path
  opl_stats_regs stats (
    .AXI_ACLK      (AXI_ACLK),
    .AXI_RESETN    (AXI_RESETN),
    .hit_ipv4      (hit_ipv4),
    .hit_arp       (hit_arp),
    .hit_ospf      (hit_ospf),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready)
  );

endmodule

// ==== opl_assertions.sv ====
// Handshake checks for the output port lookup top level
// Stream beats and read data hold until accepted

`timescale 1ns/1ps
`include "opl_defines.svh"

module opl_assertions (
  input logic                        AXI_ACLK,
  input logic                        AXI_RESETN,
  input opl_pkg::tdata_t             s_axis_tdata,
  input opl_pkg::tstrb_t             s_axis_tstrb,
  input opl_pkg::tuser_t             s_axis_tuser,
  input logic                        s_axis_tlast,
  input logic                        s_axis_tvalid,
  input logic                        s_axis_tready,
  input opl_pkg::tdata_t             m_axis_tdata,
  input opl_pkg::tstrb_t             m_axis_tstrb,
  input opl_pkg::tuser_t             m_axis_tuser,
  input logic                        m_axis_tlast,
  input logic                        m_axis_tvalid,
  input logic                        m_axis_tready,
  input logic                        s_axi_arvalid,
  input logic                        s_axi_arready,
  input logic [`OPL_AXIL_DATA_W-1:0] s_axi_rdata,
  input logic                        s_axi_rvalid,
  input logic                        s_axi_rready
);

  int fail_count = 0;

  s_axis_hold: assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
    s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid &&
      $stable({s_axis_tdata, s_axis_tstrb, s_axis_tuser, s_axis_tlast}))
    else begin
      fail_count++;
      $error("s_axis beat changed or dropped before tready");
    end

  m_axis_hold: assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid &&
      $stable({m_axis_tdata, m_axis_tstrb, m_axis_tuser, m_axis_tlast}))
    else begin
      fail_count++;
      $error("m_axis beat changed or dropped before tready");
    end

  rvalid_hold: assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
    else begin
      fail_count++;
      $error("s_axi_rvalid or rdata changed before rready");
    end

  // Read data only follows an address handshake
  rvalid_cause: assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
    $rose(s_axi_rvalid) |-> $past(s_axi_arvalid && s_axi_arready))
    else begin
      fail_count++;
      $error("s_axi_rvalid rose without an address handshake");
    end

endmodule

bind opl_top opl_assertions handshake_checks (.*);

// ==== tb_opl.sv ====
// Output port lookup testbench
// Directed tests for routing, pass-through, back-pressure, protocol
// counters and reset, with a stream driver, stream monitor and register reader

`timescale 1ns/1ps
`include "opl_defines.svh"

module tb_opl;

  localparam int TIMEOUT = 200;          // Cycles allowed per wait

  logic                        AXI_ACLK = 1'b0;
  logic                        AXI_RESETN;
  opl_pkg::tdata_t             s_axis_tdata;
  opl_pkg::tstrb_t             s_axis_tstrb;
  opl_pkg::tuser_t             s_axis_tuser;
  logic                        s_axis_tvalid;
  logic                        s_axis_tready;
  logic                        s_axis_tlast;
  opl_pkg::tdata_t             m_axis_tdata;
  opl_pkg::tstrb_t             m_axis_tstrb;
  opl_pkg::tuser_t             m_axis_tuser;
  logic                        m_axis_tvalid;
  logic                        m_axis_tready;
  logic                        m_axis_tlast;
  logic [`OPL_AXIL_ADDR_W-1:0] s_axi_araddr;
  logic                        s_axi_arvalid;
  logic                        s_axi_arready;
  logic [`OPL_AXIL_DATA_W-1:0] s_axi_rdata;
  logic [1:0]                  s_axi_rresp;
  logic                        s_axi_rvalid;
  logic                        s_axi_rready;

  opl_pkg::beat_t tx_q[$];               // Beats still to drive
  opl_pkg::beat_t exp_q[$];              // Expected output beats
  opl_pkg::beat_t rx_q[$];               // Beats seen on m_axis
  int n_ipv4;
  int n_arp;
  int n_ospf;
  int n_tests;
  int n_checks;
  int n_errors;

  opl_top uut (.*);

  always #50 AXI_ACLK = ~AXI_ACLK;

  task automatic check(input logic [255:0] got, input logic [255:0] exp, input string msg);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("Timeout at %0t ns: gave up waiting for %s", $time, what);
  endtask

  task automatic end_test(input string name, input int err_start);
    n_tests++;
    $display("Test %s finished with %0d errors", name, n_errors - err_start);
  endtask

  // Routing rules where a CPU source overrides the pairing
  function automatic opl_pkg::port_mask_t expected_dst(input opl_pkg::port_mask_t src,
                                                       input opl_pkg::port_mask_t dst_in);
    opl_pkg::port_mask_t dst;
    dst = dst_in;
    if (src[0]) dst = `OPL_PORT_NF1;     // Ascending, so the highest bit writes last
    if (src[2]) dst = `OPL_PORT_NF0;
    if (src[4]) dst = `OPL_PORT_NF3;
    if (src[6]) dst = `OPL_PORT_NF2;
    if ((src & 8'hAA) != 8'h00) dst = `OPL_PORT_NF1;
    return dst;
  endfunction

  task automatic add_packet(input logic [15:0] ethtype, input logic [3:0] ver,
                            input logic [7:0] proto, input logic [7:0] src, input int nbeats);
    opl_pkg::beat_t b;
    opl_pkg::beat_t e;
    for (int i = 0; i < nbeats; i++) begin
      for (int w = 0; w < 8; w++) b.data[w*32 +: 32] = $urandom;
      for (int w = 0; w < 4; w++) b.user[w*32 +: 32] = $urandom;
      b.strb = $urandom;
      b.last = (i == nbeats - 1);
      if (i == 0) begin
        b.data[`OPL_ETHTYPE_HI:`OPL_ETHTYPE_LO] = ethtype;
        b.data[`OPL_IPVER_HI:`OPL_IPVER_LO]     = ver;
        b.data[`OPL_PROTO_HI:`OPL_PROTO_LO]     = proto;
        b.user[`OPL_SRC_PORT_POS +: 8]          = src;
        if (ethtype == `OPL_ETHTYPE_ARP) n_arp++;
        if (ethtype == `OPL_ETHTYPE_IPV4 && ver == `OPL_IPVER_4) n_ipv4++;
        if (ethtype == `OPL_ETHTYPE_IPV4 && proto == `OPL_PROTO_OSPF) n_ospf++;
      end
      e = b;
      if (i == 0) begin
        e.user[`OPL_DST_PORT_POS +: 8] = expected_dst(src, b.user[`OPL_DST_PORT_POS +: 8]);
      end
      tx_q.push_back(b);
      exp_q.push_back(e);
    end
  endtask

  task automatic drive_beats();
    opl_pkg::beat_t b;
    int wait_cnt;
    @(posedge AXI_ACLK);
    while (tx_q.size() > 0) begin
      b = tx_q.pop_front();
      s_axis_tdata  <= b.data;
      s_axis_tstrb  <= b.strb;
      s_axis_tuser  <= b.user;
      s_axis_tlast  <= b.last;
      s_axis_tvalid <= 1'b1;
      wait_cnt = 0;
      do begin
        @(posedge AXI_ACLK);
        wait_cnt++;
      end while (!s_axis_tready && wait_cnt < TIMEOUT);
      if (!s_axis_tready) begin
        report_timeout("s_axis_tready to accept a beat");
        tx_q.delete();
      end
    end
    s_axis_tvalid <= 1'b0;
  endtask

  task automatic collect_beats(input int n, input bit random_ready);
    opl_pkg::beat_t b;
    int idle;
    idle = 0;
    while (rx_q.size() < n && idle < TIMEOUT) begin
      @(posedge AXI_ACLK);
      idle++;
      if (m_axis_tvalid && m_axis_tready) begin
        b.data = m_axis_tdata;
        b.strb = m_axis_tstrb;
        b.user = m_axis_tuser;
        b.last = m_axis_tlast;
        rx_q.push_back(b);
        idle = 0;
      end
      m_axis_tready <= random_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
    end
    m_axis_tready <= 1'b1;
    if (rx_q.size() < n) report_timeout("all output beats");
  endtask

  task automatic compare_beats();
    check(rx_q.size(), exp_q.size(), "output beat count");
    for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
      check(rx_q[i].data, exp_q[i].data, $sformatf("beat %0d tdata", i));
      check(rx_q[i].strb, exp_q[i].strb, $sformatf("beat %0d tstrb", i));
      check(rx_q[i].user, exp_q[i].user, $sformatf("beat %0d tuser", i));
      check(rx_q[i].last, exp_q[i].last, $sformatf("beat %0d tlast", i));
    end
    rx_q.delete();
    exp_q.delete();
  endtask

  task automatic run_traffic();
    int n;
    n = exp_q.size();
    fork
      drive_beats();
      collect_beats(n, 1'b0);
    join
    compare_beats();
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp, input string msg);
    int wait_cnt;
    @(posedge AXI_ACLK);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    wait_cnt = 0;
    do begin
      @(posedge AXI_ACLK);
      wait_cnt++;
    end while (!s_axi_arready && wait_cnt < TIMEOUT);
    s_axi_arvalid <= 1'b0;
    if (!s_axi_arready) begin
      report_timeout("s_axi_arready");
      return;
    end
    s_axi_rready <= 1'b1;
    wait_cnt = 0;
    do begin
      @(posedge AXI_ACLK);
      wait_cnt++;
    end while (!s_axi_rvalid && wait_cnt < TIMEOUT);
    s_axi_rready <= 1'b0;
    if (!s_axi_rvalid) begin
      report_timeout("s_axi_rvalid");
    end else begin
      check(s_axi_rdata, exp, msg);
      check(s_axi_rresp, 2'b00, {msg, " rresp"});
    end
  endtask

  task automatic apply_reset();
    @(posedge AXI_ACLK);
    AXI_RESETN    <= 1'b0;
    s_axis_tvalid <= 1'b0;
    repeat (2) @(posedge AXI_ACLK);
    AXI_RESETN    <= 1'b1;
    n_ipv4 = 0;
    n_arp  = 0;
    n_ospf = 0;
  endtask

  task automatic verify_pass_through();
    int err_start;
    err_start = n_errors;
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h01, 4);
    add_packet(`OPL_ETHTYPE_IPV4, 4'd4, 8'd6, 8'h04, 1);
    add_packet(16'h88CC, 4'd0, 8'd0, 8'h10, 3);
    run_traffic();
    end_test("pass_through", err_start);
  endtask

  task automatic route_by_source();
    int err_start;
    err_start = n_errors;
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h01, 2);    // nf1
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h04, 1);    // nf0
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h10, 2);    // nf3
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h40, 1);    // nf2
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h14, 1);    // Bit 4 beats bit 2
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h00, 2);    // Destination kept
    run_traffic();
    end_test("port_lookup", err_start);
  endtask

  task automatic route_cpu_traffic();
    int err_start;
    err_start = n_errors;
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h02, 3);
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h08, 3);
    add_packet(16'h86DD, 4'd6, 8'd17, 8'h20, 2);
    add_packet(16'h86DD, 4'd6, 8'd17, 8'hC5, 3);    // Odd bit among pairs
    run_traffic();
    end_test("cpu_source", err_start);
  endtask

  task automatic count_protocols();
    int err_start;
    err_start = n_errors;
    add_packet(`OPL_ETHTYPE_ARP, 4'd0, 8'd0, 8'h01, 1);
    add_packet(`OPL_ETHTYPE_ARP, 4'd4, 8'd89, 8'h04, 2);
    add_packet(`OPL_ETHTYPE_IPV4, 4'd4, 8'd6, 8'h10, 2);
    add_packet(`OPL_ETHTYPE_IPV4, 4'd4, `OPL_PROTO_OSPF, 8'h40, 3);
    add_packet(`OPL_ETHTYPE_IPV4, 4'd6, `OPL_PROTO_OSPF, 8'h02, 1);  // OSPF, not v4
    add_packet(`OPL_ETHTYPE_IPV4, 4'd5, 8'd17, 8'h01, 1);
    add_packet(16'h86DD, 4'd4, `OPL_PROTO_OSPF, 8'h04, 2);
    run_traffic();
    read_reg(`OPL_REG_IPV4, n_ipv4, "IPv4 counter");
    read_reg(`OPL_REG_ARP, n_arp, "ARP counter");
    read_reg(`OPL_REG_OSPF, n_ospf, "OSPF counter");
    read_reg(`OPL_REG_SPARE, 32'h0, "spare register");
    end_test("statistics", err_start);
  endtask

  task automatic survive_backpressure();
    int err_start;
    int n;
    int wait_cnt;
    bit stalled;
    err_start = n_errors;
    for (int p = 0; p < 5; p++) add_packet(16'h86DD, 4'd6, 8'd17, 8'h01 << p, 3);
    n = exp_q.size();
    @(posedge AXI_ACLK);
    m_axis_tready <= 1'b0;
    fork
      drive_beats();
      begin
        stalled  = 1'b0;
        wait_cnt = 0;
        while (!stalled && wait_cnt < TIMEOUT) begin
          @(posedge AXI_ACLK);
          wait_cnt++;
          stalled = !s_axis_tready;
        end
        if (!stalled) begin
          n_errors++;
          $display("Error at %0t ns: s_axis_tready stayed high with the output stalled", $time);
        end
        collect_beats(n, 1'b1);
      end
    join
    compare_beats();
    end_test("backpressure", err_start);
  endtask

  task automatic clear_on_reset();
    int err_start;
    int wait_cnt;
    err_start = n_errors;
    add_packet(`OPL_ETHTYPE_ARP, 4'd0, 8'd0, 8'h01, 2);
    @(posedge AXI_ACLK);
    m_axis_tready <= 1'b0;
    drive_beats();
    wait_cnt = 0;
    while (!m_axis_tvalid && wait_cnt < TIMEOUT) begin
      @(posedge AXI_ACLK);
      wait_cnt++;
    end
    if (!m_axis_tvalid) report_timeout("m_axis_tvalid before reset");
    apply_reset();
    m_axis_tready <= 1'b1;
    exp_q.delete();
    @(posedge AXI_ACLK);
    check(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
    check(s_axis_tready, 1'b1, "s_axis_tready after reset");
    check(s_axi_rvalid, 1'b0, "s_axi_rvalid after reset");
    check(s_axi_arready, 1'b1, "s_axi_arready after reset");
    read_reg(`OPL_REG_IPV4, 32'h0, "IPv4 counter after reset");
    read_reg(`OPL_REG_ARP, 32'h0, "ARP counter after reset");
    read_reg(`OPL_REG_OSPF, 32'h0, "OSPF counter after reset");
    end_test("reset", err_start);
  endtask

  initial begin
    void'($urandom(32'heb2a5d33));
    AXI_RESETN    = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tstrb  = '0;
    s_axis_tuser  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b1;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    n_tests  = 0;
    n_checks = 0;
    n_errors = 0;
    apply_reset();
    verify_pass_through();
    route_by_source();
    route_cpu_traffic();
    count_protocols();
    survive_backpressure();
    clear_on_reset();
    n_errors += uut.handshake_checks.fail_count;
    $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
opl_pkg.sv
opl_beat_fifo.sv
opl_pkt_classifier.sv
opl_port_lookup.sv
opl_stats_regs.sv
opl_top.sv
opl_assertions.sv
tb_opl.sv
